//--- verilog/despreader_pkg.sv
/*
 * Shared definitions for the despreader.
 * Register address map, despread mode encoding, code width
 * and the register data word with its code and control views.
 */

package despreader_pkg;

    localparam int code_width = 18; // lfsr state and code register width.

    // code a registers.
    localparam logic [11:0] addr_init_a          = 12'h000;
    localparam logic [11:0] addr_poly_taps_a     = 12'h004;
    localparam logic [11:0] addr_restart_count_a = 12'h008;
    localparam logic [11:0] addr_i_out_taps_a    = 12'h00c;
    localparam logic [11:0] addr_q_out_taps_a    = 12'h010;

    // code b registers.
    localparam logic [11:0] addr_init_b          = 12'h020;
    localparam logic [11:0] addr_poly_taps_b     = 12'h024;
    localparam logic [11:0] addr_restart_count_b = 12'h028;
    localparam logic [11:0] addr_i_out_taps_b    = 12'h02c;
    localparam logic [11:0] addr_q_out_taps_b    = 12'h030;

    localparam logic [11:0] addr_control         = 12'h040;

    localparam logic [1:0] mode_idle    = 2'd0; // no despreading.
    localparam logic [1:0] mode_code_a  = 2'd1;
    localparam logic [1:0] mode_code_b  = 2'd2;
    localparam logic [1:0] mode_code_ab = 2'd3; // i on code a, q on code b.

    typedef union packed {
        struct packed {
            logic [31-code_width:0] pad;
            logic [code_width-1:0]  value;
        } code;
        struct packed {
            logic [29:0] pad;
            logic [1:0]  mode;
        } control;
    } reg_word_t;

endpackage

//--- verilog/despreader_regs.sv
/*
 * Host register file for the despreader.
 * Code A and code B settings plus the control register,
 * byte-lane writes on clk, zero-extended readback and the restart pulse.
 */

`timescale 1ns/10ps

module despreader_regs
    import despreader_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cs,
    input  logic [3:0]            wr,
    input  logic [11:0]           addr,
    input  logic [31:0]           din,
    output logic [31:0]           dout,
    output logic [1:0]            despread_mode,
    output logic [code_width-1:0] init_a,
    output logic [code_width-1:0] poly_taps_a,
    output logic [code_width-1:0] restart_count_a,
    output logic [code_width-1:0] i_out_taps_a,
    output logic [code_width-1:0] q_out_taps_a,
    output logic [code_width-1:0] init_b,
    output logic [code_width-1:0] poly_taps_b,
    output logic [code_width-1:0] restart_count_b,
    output logic [code_width-1:0] i_out_taps_b,
    output logic [code_width-1:0] q_out_taps_b,
    output logic                  code_restart
);

    reg_word_t             wr_word;
    reg_word_t             rd_word;
    logic                  wr_en;
    logic [code_width-1:0] wr_value;
    logic [2:0]            lanes;

    // merge the enabled byte lanes into an 18-bit register.
    function automatic logic [code_width-1:0] lane_merge(
        input logic [code_width-1:0] old_val,
        input logic [code_width-1:0] new_val,
        input logic [2:0]            strobe
    );
        logic [code_width-1:0] merged;
        merged = old_val;
        if (strobe[0]) merged[7:0] = new_val[7:0];
        if (strobe[1]) merged[15:8] = new_val[15:8];
        if (strobe[2]) merged[17:16] = new_val[17:16];
        return merged;
    endfunction

    assign wr_word  = din;
    assign wr_value = wr_word.code.value;
    assign lanes    = wr[2:0]; // lane 3 has no bits to write.
    assign wr_en    = cs && (wr != 4'b0000);

    always_ff @(posedge clk) begin
        if (rst) begin
            despread_mode   <= mode_idle;
            init_a          <= '0;
            poly_taps_a     <= '0;
            restart_count_a <= '0;
            i_out_taps_a    <= '0;
            q_out_taps_a    <= '0;
            init_b          <= '0;
            poly_taps_b     <= '0;
            restart_count_b <= '0;
            i_out_taps_b    <= '0;
            q_out_taps_b    <= '0;
            code_restart    <= 1'b0;
        end else begin
            code_restart <= wr_en && (addr == addr_control); // one cycle after the write.
            if (wr_en) begin
                case (addr)
                    addr_init_a:          init_a <= lane_merge(init_a, wr_value, lanes);
                    addr_poly_taps_a:     poly_taps_a <= lane_merge(poly_taps_a, wr_value, lanes);
                    addr_restart_count_a:
                        restart_count_a <= lane_merge(restart_count_a, wr_value, lanes);
                    addr_i_out_taps_a:    i_out_taps_a <= lane_merge(i_out_taps_a, wr_value, lanes);
                    addr_q_out_taps_a:    q_out_taps_a <= lane_merge(q_out_taps_a, wr_value, lanes);
                    addr_init_b:          init_b <= lane_merge(init_b, wr_value, lanes);
                    addr_poly_taps_b:     poly_taps_b <= lane_merge(poly_taps_b, wr_value, lanes);
                    addr_restart_count_b:
                        restart_count_b <= lane_merge(restart_count_b, wr_value, lanes);
                    addr_i_out_taps_b:    i_out_taps_b <= lane_merge(i_out_taps_b, wr_value, lanes);
                    addr_q_out_taps_b:    q_out_taps_b <= lane_merge(q_out_taps_b, wr_value, lanes);
                    addr_control:         if (wr[0]) despread_mode <= wr_word.control.mode;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rd_word = '0; // unselected or unmapped reads give zero.
        if (cs) begin
            case (addr)
                addr_init_a:          rd_word.code.value = init_a;
                addr_poly_taps_a:     rd_word.code.value = poly_taps_a;
                addr_restart_count_a: rd_word.code.value = restart_count_a;
                addr_i_out_taps_a:    rd_word.code.value = i_out_taps_a;
                addr_q_out_taps_a:    rd_word.code.value = q_out_taps_a;
                addr_init_b:          rd_word.code.value = init_b;
                addr_poly_taps_b:     rd_word.code.value = poly_taps_b;
                addr_restart_count_b: rd_word.code.value = restart_count_b;
                addr_i_out_taps_b:    rd_word.code.value = i_out_taps_b;
                addr_q_out_taps_b:    rd_word.code.value = q_out_taps_b;
                addr_control:         rd_word.control.mode = despread_mode;
                default: ;
            endcase
        end
    end

    assign dout = rd_word;

endmodule

//--- verilog/code_generator.sv
/*
 * Programmable 18-bit Fibonacci LFSR code generator.
 * I and Q chip taps, chip counter with seed reload
 * and an epoch flag on the last chip of each period.
 */

`timescale 1ns/10ps

module code_generator
    import despreader_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sample_valid,
    input  logic                  code_restart,
    input  logic [code_width-1:0] init,
    input  logic [code_width-1:0] poly_taps,
    input  logic [code_width-1:0] restart_count,
    input  logic [code_width-1:0] i_out_taps,
    input  logic [code_width-1:0] q_out_taps,
    output logic                  i_chip,
    output logic                  q_chip,
    output logic                  epoch
);

    logic [code_width-1:0] state;
    logic [code_width-1:0] chip_count;
    logic [code_width-1:0] period_end;
    logic                  feedback;

    assign feedback = ^(state & poly_taps);
    assign i_chip   = ^(state & i_out_taps);
    assign q_chip   = ^(state & q_out_taps);

    // a count of zero behaves as a one-chip period.
    assign period_end = (restart_count == '0) ? '0 : restart_count - 1'b1;

    // high while the current chip is the last of the period.
    assign epoch = (chip_count == period_end);

    always_ff @(posedge clk) begin
        if (rst || code_restart) begin
            state      <= init;
            chip_count <= '0;
        end else if (sample_valid) begin
            if (epoch) begin
                state      <= init; // start the next period from the seed.
                chip_count <= '0;
            end else begin
                state      <= {state[code_width-2:0], feedback};
                chip_count <= chip_count + 1'b1;
            end
        end
    end

endmodule

//--- verilog/despreader_correlator.sv
/*
 * Despread correlator.
 * Selects chips and period marker by mode, accumulates
 * sign-flipped I and Q samples and emits one symbol per period.
 */

`timescale 1ns/10ps

module despreader_correlator
    import despreader_pkg::*;
#(
    parameter int sample_width = 8
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   sample_valid,
    input  logic                                   code_restart,
    input  logic [1:0]                             despread_mode,
    input  logic signed [sample_width-1:0]         sample_i,
    input  logic signed [sample_width-1:0]         sample_q,
    input  logic                                   i_chip_a,
    input  logic                                   q_chip_a,
    input  logic                                   epoch_a,
    input  logic                                   i_chip_b,
    input  logic                                   q_chip_b,
    input  logic                                   epoch_b,
    output logic                                   symbol_valid,
    output logic signed [sample_width+code_width-1:0] acc_i,
    output logic signed [sample_width+code_width-1:0] acc_q
);

    localparam int acc_width = sample_width + code_width;

    logic                        chip_i;
    logic                        chip_q;
    logic                        period_mark;
    logic                        symbol_end;
    logic signed [acc_width-1:0] term_i;
    logic signed [acc_width-1:0] term_q;
    logic signed [acc_width-1:0] sum_i;
    logic signed [acc_width-1:0] sum_q;
    logic signed [acc_width-1:0] next_i;
    logic signed [acc_width-1:0] next_q;

    always_comb begin
        case (despread_mode)
            mode_code_a: {chip_i, chip_q, period_mark} = {i_chip_a, q_chip_a, epoch_a};
            mode_code_b: {chip_i, chip_q, period_mark} = {i_chip_b, q_chip_b, epoch_b};
            mode_code_ab: {chip_i, chip_q, period_mark} = {i_chip_a, q_chip_b, epoch_a};
            default: {chip_i, chip_q, period_mark} = 3'b000; // idle.
        endcase
    end

    // extend before negating so the most negative sample stays exact.
    assign term_i = chip_i ? -acc_width'(sample_i) : acc_width'(sample_i);
    assign term_q = chip_q ? -acc_width'(sample_q) : acc_width'(sample_q);
    assign next_i = sum_i + term_i;
    assign next_q = sum_q + term_q;

    assign symbol_end = sample_valid && period_mark && !code_restart;

    always_ff @(posedge clk) begin
        if (rst || code_restart || (despread_mode == mode_idle)) begin
            sum_i        <= '0;
            sum_q        <= '0;
            symbol_valid <= 1'b0;
        end else begin
            symbol_valid <= symbol_end;
            if (symbol_end) begin
                sum_i <= '0;
                sum_q <= '0;
            end else if (sample_valid) begin
                sum_i <= next_i;
                sum_q <= next_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (symbol_end) begin
            acc_i <= next_i; // includes the epoch sample.
            acc_q <= next_q;
        end
    end

endmodule

//--- verilog/despreader_top.sv
/*
 * Despreader top level.
 * Register file, code generators A and B and the correlator.
 */

`timescale 1ns/10ps

module despreader_top
    import despreader_pkg::*;
#(
    parameter int sample_width = 8
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      cs,
    input  logic [3:0]                                wr,
    input  logic [11:0]                               addr,
    input  logic [31:0]                               din,
    output logic [31:0]                               dout,
    input  logic                                      sample_valid,
    input  logic signed [sample_width-1:0]            sample_i,
    input  logic signed [sample_width-1:0]            sample_q,
    output logic                                      symbol_valid,
    output logic signed [sample_width+code_width-1:0] acc_i,
    output logic signed [sample_width+code_width-1:0] acc_q
);

    logic [1:0]            despread_mode;
    logic                  code_restart;
    logic [code_width-1:0] init_a;
    logic [code_width-1:0] poly_taps_a;
    logic [code_width-1:0] restart_count_a;
    logic [code_width-1:0] i_out_taps_a;
    logic [code_width-1:0] q_out_taps_a;
    logic [code_width-1:0] init_b;
    logic [code_width-1:0] poly_taps_b;
    logic [code_width-1:0] restart_count_b;
    logic [code_width-1:0] i_out_taps_b;
    logic [code_width-1:0] q_out_taps_b;
    logic                  i_chip_a;
    logic                  q_chip_a;
    logic                  epoch_a;
    logic                  i_chip_b;
    logic                  q_chip_b;
    logic                  epoch_b;

    despreader_regs regs_i (
        .clk(clk), .rst(rst), .cs(cs), .wr(wr), .addr(addr), .din(din), .dout(dout),
        .despread_mode(despread_mode),
        .init_a(init_a), .poly_taps_a(poly_taps_a), .restart_count_a(restart_count_a),
        .i_out_taps_a(i_out_taps_a), .q_out_taps_a(q_out_taps_a),
        .init_b(init_b), .poly_taps_b(poly_taps_b), .restart_count_b(restart_count_b),
        .i_out_taps_b(i_out_taps_b), .q_out_taps_b(q_out_taps_b),
        .code_restart(code_restart)
    );

    code_generator gen_a (
        .clk(clk), .rst(rst), .sample_valid(sample_valid), .code_restart(code_restart),
        .init(init_a), .poly_taps(poly_taps_a), .restart_count(restart_count_a),
        .i_out_taps(i_out_taps_a), .q_out_taps(q_out_taps_a),
        .i_chip(i_chip_a), .q_chip(q_chip_a), .epoch(epoch_a)
    );

    code_generator gen_b (
        .clk(clk), .rst(rst), .sample_valid(sample_valid), .code_restart(code_restart),
        .init(init_b), .poly_taps(poly_taps_b), .restart_count(restart_count_b),
        .i_out_taps(i_out_taps_b), .q_out_taps(q_out_taps_b),
        .i_chip(i_chip_b), .q_chip(q_chip_b), .epoch(epoch_b)
    );

    despreader_correlator #(
        .sample_width(sample_width)
    ) correlator_i (
        .clk(clk), .rst(rst), .sample_valid(sample_valid), .code_restart(code_restart),
        .despread_mode(despread_mode), .sample_i(sample_i), .sample_q(sample_q),
        .i_chip_a(i_chip_a), .q_chip_a(q_chip_a), .epoch_a(epoch_a),
        .i_chip_b(i_chip_b), .q_chip_b(q_chip_b), .epoch_b(epoch_b),
        .symbol_valid(symbol_valid), .acc_i(acc_i), .acc_q(acc_q)
    );

endmodule

//--- verif/despreader_clock.sv
/*
 * Testbench clock and reset generator.
 */

`timescale 1ns/10ps

module despreader_clock #(
    parameter real period_ns    = 4.0,
    parameter int  reset_cycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0; // released on a falling edge like the other inputs.
    end

endmodule

//--- verif/despreader_tb.sv
/*
 * Directed testbench for the despreader.
 * Register, idle, code A, code B, mixed mode and restart tests
 * checked against a reference LFSR and correlator model.
 */

`timescale 1ns/10ps

module despreader_tb
    import despreader_pkg::*;
();

    localparam int sample_width   = 8;
    localparam int acc_width      = sample_width + code_width;
    localparam int timeout_cycles = 200;

    // fields of code a then code b: init, poly, count, i taps, q taps.
    localparam logic [11:0] code_addr [10] = '{
        addr_init_a, addr_poly_taps_a, addr_restart_count_a, addr_i_out_taps_a, addr_q_out_taps_a,
        addr_init_b, addr_poly_taps_b, addr_restart_count_b, addr_i_out_taps_b, addr_q_out_taps_b
    };

    logic                           clk;
    logic                           rst;
    logic                           cs;
    logic [3:0]                     wr;
    logic [11:0]                    addr;
    logic [31:0]                    din;
    logic [31:0]                    dout;
    logic                           sample_valid;
    logic signed [sample_width-1:0] sample_i;
    logic signed [sample_width-1:0] sample_q;
    logic                           symbol_valid;
    logic signed [acc_width-1:0]    acc_i;
    logic signed [acc_width-1:0]    acc_q;
    integer                         seed;
    int                             received;

    logic [code_width-1:0]       model_cfg [10]; // same order as code_addr.
    logic [code_width-1:0]       model_state [2];
    int                          model_count [2];
    logic [1:0]                  model_mode;
    logic signed [acc_width-1:0] model_sum_i;
    logic signed [acc_width-1:0] model_sum_q;
    logic signed [acc_width-1:0] exp_i [$];
    logic signed [acc_width-1:0] exp_q [$];

    despreader_clock clock_i (.clk(clk), .rst(rst));

    despreader_top #(
        .sample_width(sample_width)
    ) dut_i (
        .clk(clk), .rst(rst), .cs(cs), .wr(wr), .addr(addr), .din(din), .dout(dout),
        .sample_valid(sample_valid), .sample_i(sample_i), .sample_q(sample_q),
        .symbol_valid(symbol_valid), .acc_i(acc_i), .acc_q(acc_q)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input string test, input longint expected, input longint actual);
        assert (expected == actual)
        else fail_run($sformatf("MISMATCH %s: expected %0d, actual %0d", test, expected, actual));
    endtask

    task automatic write_reg(input logic [11:0] reg_addr, input logic [31:0] data,
                             input logic [3:0] strobe);
        @(negedge clk);
        cs   = 1'b1;
        wr   = strobe;
        addr = reg_addr;
        din  = data;
        @(negedge clk);
        cs = 1'b0;
        wr = 4'b0000;
    endtask

    task automatic expect_reg(input string test, input logic [11:0] reg_addr,
                              input logic select, input logic [31:0] expected);
        @(negedge clk);
        cs   = select;
        wr   = 4'b0000;
        addr = reg_addr;
        #1; // readback is combinational.
        check_equal(test, longint'(expected), longint'(dout));
        cs = 1'b0;
    endtask

    // lanes 0 to 2 reach the 18 code bits, lane 3 reaches nothing.
    function automatic logic [31:0] lane_update(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strobe);
        logic [31:0] mask;
        mask = {8'h00, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}} & 32'h0003_ffff;
        return (old & ~mask) | (data & mask);
    endfunction

    task automatic program_code(input int g, input logic [code_width-1:0] fields [5]);
        for (int f = 0; f < 5; f++) begin
            write_reg(code_addr[g*5+f], 32'(fields[f]), 4'b1111);
            model_cfg[g*5+f] = fields[f];
        end
    endtask

    task automatic set_mode(input logic [1:0] mode);
        write_reg(addr_control, {30'b0, mode}, 4'b0001);
        for (int g = 0; g < 2; g++) begin
            model_state[g] = model_cfg[g*5]; // restart pulse reloads both seeds.
            model_count[g] = 0;
        end
        model_mode  = mode;
        model_sum_i = '0;
        model_sum_q = '0;
    endtask

    task automatic model_sample(input logic signed [sample_width-1:0] si,
                                input logic signed [sample_width-1:0] sq);
        logic [1:0]                  chip_i;
        logic [1:0]                  chip_q;
        logic [1:0]                  last;
        logic                        use_i;
        logic                        use_q;
        logic                        mark;
        logic signed [acc_width-1:0] ext_i;
        logic signed [acc_width-1:0] ext_q;
        int                          period;
        for (int g = 0; g < 2; g++) begin
            chip_i[g] = ^(model_state[g] & model_cfg[g*5+3]);
            chip_q[g] = ^(model_state[g] & model_cfg[g*5+4]);
            period    = (model_cfg[g*5+2] == '0) ? 1 : int'(model_cfg[g*5+2]);
            last[g]   = (model_count[g] + 1 == period);
            if (last[g]) begin
                model_state[g] = model_cfg[g*5];
                model_count[g] = 0;
            end else begin
                model_state[g] = {model_state[g][code_width-2:0],
                                  ^(model_state[g] & model_cfg[g*5+1])};
                model_count[g]++;
            end
        end
        case (model_mode)
            mode_code_a:  {use_i, use_q, mark} = {chip_i[0], chip_q[0], last[0]};
            mode_code_b:  {use_i, use_q, mark} = {chip_i[1], chip_q[1], last[1]};
            mode_code_ab: {use_i, use_q, mark} = {chip_i[0], chip_q[1], last[0]};
            default:      return; // sums stay at zero while idle.
        endcase
        ext_i = acc_width'(si);
        ext_q = acc_width'(sq);
        model_sum_i += use_i ? -ext_i : ext_i;
        model_sum_q += use_q ? -ext_q : ext_q;
        if (mark) begin
            exp_i.push_back(model_sum_i);
            exp_q.push_back(model_sum_q);
            model_sum_i = '0;
            model_sum_q = '0;
        end
    endtask

    task automatic collect_symbol(input string test);
        if (symbol_valid) begin
            assert (exp_i.size() > 0)
            else fail_run($sformatf("%s: symbol_valid rose when no symbol was due", test));
            check_equal(test, longint'(exp_i.pop_front()), longint'(acc_i));
            check_equal(test, longint'(exp_q.pop_front()), longint'(acc_q));
            received++;
        end
    endtask

    task automatic send_samples(input string test, input int n);
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            collect_symbol(test);
            sample_valid = 1'b1;
            sample_i     = sample_width'($random(seed));
            sample_q     = sample_width'($random(seed));
            model_sample(sample_i, sample_q);
        end
        @(negedge clk);
        collect_symbol(test);
        sample_valid = 1'b0;
    endtask

    task automatic wait_symbols(input string test, input int count);
        int cycles;
        cycles = 0;
        while (exp_i.size() > 0) begin
            @(negedge clk);
            collect_symbol(test);
            cycles++;
            if (cycles > timeout_cycles) begin
                fail_run($sformatf("%s: timed out waiting for symbol_valid", test));
            end
        end
        check_equal(test, longint'(count), longint'(received));
    endtask

    task automatic watch_quiet(input string test, input int n);
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            collect_symbol(test);
        end
    endtask

    task automatic reset_values();
        for (int r = 0; r < 10; r++) begin
            expect_reg("reset_values", code_addr[r], 1'b1, 32'h0);
        end
        expect_reg("reset_values", addr_control, 1'b1, 32'h0);
        watch_quiet("reset_values", 8);
    endtask

    task automatic reg_access();
        logic [31:0] shadow [10];
        logic [31:0] data;
        logic [3:0]  strobes [6];
        strobes = '{4'b1111, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0110};
        for (int r = 0; r < 10; r++) begin
            shadow[r] = 32'h0;
            foreach (strobes[s]) begin
                data = $random(seed);
                write_reg(code_addr[r], data, strobes[s]);
                shadow[r] = lane_update(shadow[r], data, strobes[s]);
                expect_reg("reg_access", code_addr[r], 1'b1, shadow[r]);
            end
        end
        write_reg(12'h044, 32'hffff_ffff, 4'b1111);
        for (int r = 0; r < 10; r++) begin
            expect_reg("reg_access", code_addr[r], 1'b1, shadow[r]);
        end
        write_reg(addr_control, 32'hffff_ffff, 4'b1111);
        expect_reg("reg_access control", addr_control, 1'b1, 32'h3);
        write_reg(addr_control, 32'h0, 4'b1110);
        expect_reg("reg_access control", addr_control, 1'b1, 32'h3);
        write_reg(addr_control, 32'h0, 4'b0001);
        expect_reg("reg_access control", addr_control, 1'b1, 32'h0);
        expect_reg("reg_access unmapped", 12'h014, 1'b1, 32'h0);
        expect_reg("reg_access unmapped", 12'h044, 1'b1, 32'h0);
        expect_reg("reg_access unmapped", 12'hffc, 1'b1, 32'h0);
        expect_reg("reg_access cs low", code_addr[0], 1'b0, 32'h0);
    endtask

    task automatic idle_mode();
        // short periods so both generators mark epochs during the burst.
        program_code(0, '{18'h0f0f1, 18'h20400, 18'd6, 18'h00811, 18'h05100});
        program_code(1, '{18'h1b3d7, 18'h20040, 18'd5, 18'h00306, 18'h08005});
        set_mode(mode_idle);
        send_samples("idle_mode", 40);
        watch_quiet("idle_mode", timeout_cycles);
    endtask

    task automatic code_a_despread();
        program_code(0, '{18'h2a5c3, 18'h20400, 18'd15, 18'h00811, 18'h05100});
        program_code(1, '{18'h1b3d7, 18'h20040, 18'd11, 18'h00306, 18'h08005});
        set_mode(mode_code_a);
        received = 0;
        send_samples("code_a_despread", 45);
        wait_symbols("code_a_despread", 3);
    endtask

    task automatic code_b_and_ab();
        set_mode(mode_code_b);
        received = 0;
        send_samples("code_b_and_ab mode b", 33);
        wait_symbols("code_b_and_ab mode b", 3);
        set_mode(mode_code_ab); // period comes from code a here.
        received = 0;
        send_samples("code_b_and_ab mode ab", 45);
        wait_symbols("code_b_and_ab mode ab", 3);
    endtask

    task automatic restart_realign();
        set_mode(mode_code_a);
        received = 0;
        send_samples("restart_realign", 7);
        set_mode(mode_code_a);
        send_samples("restart_realign", 15);
        wait_symbols("restart_realign", 1);
    endtask

    initial begin
        int cycles;
        seed         = 62;
        received     = 0;
        cs           = 1'b0;
        wr           = 4'b0000;
        addr         = 12'h000;
        din          = 32'h0;
        sample_valid = 1'b0;
        sample_i     = '0;
        sample_q     = '0;
        model_mode   = mode_idle;
        cycles       = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                fail_run("reset was never released");
            end
        end
        reset_values();
        reg_access();
        idle_mode();
        code_a_despread();
        code_b_and_ab();
        restart_realign();
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- despreader_top.f
verilog/despreader_pkg.sv
verilog/despreader_regs.sv
verilog/code_generator.sv
verilog/despreader_correlator.sv
verilog/despreader_top.sv
verif/despreader_clock.sv
verif/despreader_tb.sv

//--- Makefile
# Verilator build and run for the despreader testbench.

VERILATOR ?= verilator
TOP       ?= despreader_tb
RTL_TOP   ?= despreader_top
FILELIST  ?= despreader_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

RTL_SRCS := $(shell grep '^verilog/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
